//--- Makefile
TOP := tb_vga_sram

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

//--- design/frame_seq.sv
`timescale 1ns/1ps

module frame_seq #(
  parameter int ADDR_W   = 20,
  parameter int DATA_W   = 16,
  parameter int H_ACTIVE = 8,
  parameter int V_ACTIVE = 6
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              start,
  input  vga_pkg::pattern_t pattern,
  input  logic              fifo_almost_full,
  output logic              fill_done,
  output logic              adv,
  output logic              wr_en,
  output logic [ADDR_W-1:0] wr_addr,
  output logic [DATA_W-1:0] wr_data
);

  vga_pkg::seq_state_t state;
  vga_pkg::pattern_t   pat_q;
  logic [15:0]         x;
  logic [15:0]         y;
  logic [ADDR_W-1:0]   fill_addr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= vga_pkg::IDLE;
      pat_q     <= vga_pkg::PAT_SOLID;
      x         <= '0;
      y         <= '0;
      fill_addr <= '0;
    end else begin
      case (state)
        vga_pkg::IDLE: begin
          if (start) begin
            state <= vga_pkg::FILL;
            pat_q <= pattern;
          end
        end
        vga_pkg::FILL: begin
          // row-major walk, fill_addr tracks y * H_ACTIVE + x
          fill_addr <= fill_addr + 1'b1;
          if (x == 16'(H_ACTIVE - 1)) begin
            x <= '0;
            if (y == 16'(V_ACTIVE - 1)) state <= vga_pkg::STREAM;
            else y <= y + 16'd1;
          end else begin
            x <= x + 16'd1;
          end
        end
        default: state <= vga_pkg::STREAM;
      endcase
    end
  end

  assign wr_en     = (state == vga_pkg::FILL);
  assign wr_addr   = fill_addr;
  assign wr_data   = {{(DATA_W - vga_pkg::COLOR_W){1'b0}}, vga_pkg::pattern_color(pat_q, x, y)};
  assign fill_done = (state == vga_pkg::STREAM);
  assign adv       = fill_done && !fifo_almost_full;

  // the raster only moves once every frame address has been written
  a_adv_after_fill: assert property (@(posedge clk) disable iff (!arst_n)
    adv |-> fill_addr == ADDR_W'(H_ACTIVE * V_ACTIVE));

endmodule

//--- design/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 3,
  parameter int ALMOST_FULL_BUF = 4
) (
  input  logic                      w_clk,
  input  logic                      w_arst_n,
  input  logic                      w_inc,
  input  logic [vga_pkg::PIX_W-1:0] w_data,
  output logic                      w_full,
  output logic                      w_almost_full,
  input  logic                      r_clk,
  input  logic                      r_arst_n,
  output logic                      r_valid,
  output logic [vga_pkg::PIX_W-1:0] r_data
);

  localparam int A     = FIFO_DEPTH_LOG2;
  localparam int DEPTH = 1 << A;

  function automatic logic [A:0] gray2bin(input logic [A:0] g);
    logic [A:0] b;
    for (int i = 0; i <= A; i++) b[i] = ^(g >> i);
    return b;
  endfunction

  logic [vga_pkg::PIX_W-1:0] mem [DEPTH];

  logic [A:0] w_bin;
  logic [A:0] w_gray;
  logic [A:0] rq1_gray;
  logic [A:0] rq2_gray;
  logic [A:0] w_count;
  logic [A:0] r_bin;
  logic [A:0] r_gray;
  logic [A:0] wq1_gray;
  logic [A:0] wq2_gray;
  logic       r_empty;

  // write side, occupancy seen through the synchronized read pointer
  assign w_count       = w_bin - gray2bin(rq2_gray);
  assign w_full        = (w_count == (A + 1)'(DEPTH));
  assign w_almost_full = (w_count >= (A + 1)'(DEPTH - ALMOST_FULL_BUF));

  always_ff @(posedge w_clk) begin
    if (w_inc) mem[w_bin[A-1:0]] <= w_data;
  end

  always_ff @(posedge w_clk or negedge w_arst_n) begin
    if (!w_arst_n) begin
      w_bin    <= '0;
      w_gray   <= '0;
      rq1_gray <= '0;
      rq2_gray <= '0;
    end else begin
      rq1_gray <= r_gray;
      rq2_gray <= rq1_gray;
      if (w_inc) begin
        w_bin  <= w_bin + 1'b1;
        w_gray <= (w_bin + 1'b1) ^ ((w_bin + 1'b1) >> 1);
      end
    end
  end

  // read side pops on every cycle with data
  assign r_empty = (r_gray == wq2_gray);

  always_ff @(posedge r_clk or negedge r_arst_n) begin
    if (!r_arst_n) begin
      r_bin    <= '0;
      r_gray   <= '0;
      wq1_gray <= '0;
      wq2_gray <= '0;
      r_valid  <= 1'b0;
    end else begin
      wq1_gray <= w_gray;
      wq2_gray <= wq1_gray;
      r_valid  <= !r_empty;
      if (!r_empty) begin
        r_bin  <= r_bin + 1'b1;
        r_gray <= (r_bin + 1'b1) ^ ((r_bin + 1'b1) >> 1);
      end
    end
  end

  always_ff @(posedge r_clk) begin
    if (!r_empty) r_data <= mem[r_bin[A-1:0]];
  end

  a_no_overflow: assert property (@(posedge w_clk) disable iff (!w_arst_n) w_inc |-> !w_full);

  // the read pointer never runs past the write pointer it has seen
  a_no_underflow: assert property (@(posedge r_clk) disable iff (!r_arst_n)
    (gray2bin(wq2_gray) - r_bin) <= (A + 1)'(DEPTH));

endmodule

//--- design/raster_timer.sv
`timescale 1ns/1ps

module raster_timer #(
  parameter int ADDR_W       = 20,
  parameter int H_ACTIVE     = 8,
  parameter int H_TOTAL      = 12,
  parameter int H_SYNC_START = 9,
  parameter int H_SYNC_END   = 10,
  parameter int V_ACTIVE     = 6,
  parameter int V_TOTAL      = 8,
  parameter int V_SYNC_START = 6,
  parameter int V_SYNC_END   = 6
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              adv,
  output logic              pos_valid,
  output logic              rd_en,
  output logic [ADDR_W-1:0] rd_addr,
  output logic [2:0]        tag
);

  logic [15:0]       h;
  logic [15:0]       v;
  logic [ADDR_W-1:0] addr;
  logic              active;
  logic              hsync_n;
  logic              vsync_n;
  logic              h_last;
  logic              v_last;

  assign active  = (h < 16'(H_ACTIVE)) && (v < 16'(V_ACTIVE));
  // sync pulses are active low and include both end counts
  assign hsync_n = !((h >= 16'(H_SYNC_START)) && (h <= 16'(H_SYNC_END)));
  assign vsync_n = !((v >= 16'(V_SYNC_START)) && (v <= 16'(V_SYNC_END)));
  assign h_last  = (h == 16'(H_TOTAL - 1));
  assign v_last  = (v == 16'(V_TOTAL - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h         <= '0;
      v         <= '0;
      addr      <= '0;
      pos_valid <= 1'b0;
      rd_en     <= 1'b0;
      rd_addr   <= '0;
      tag       <= 3'b110;
    end else begin
      pos_valid <= adv;
      rd_en     <= adv && active;
      if (adv) begin
        rd_addr <= addr;
        tag     <= {hsync_n, vsync_n, active};
        if (h_last) begin
          h <= '0;
          v <= v_last ? '0 : v + 16'd1;
        end else begin
          h <= h + 16'd1;
        end
        // address restarts with every frame
        if (h_last && v_last) addr <= '0;
        else if (active) addr <= addr + 1'b1;
      end
    end
  end

endmodule

//--- design/sram_port.sv
`timescale 1ns/1ps

module sram_port #(
  parameter int ADDR_W = 20,
  parameter int DATA_W = 16
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        wr_en,
  input  logic [ADDR_W-1:0]           wr_addr,
  input  logic [DATA_W-1:0]           wr_data,
  input  logic                        pos_valid,
  input  logic                        rd_en,
  input  logic [ADDR_W-1:0]           rd_addr,
  input  logic [2:0]                  tag,
  input  logic [DATA_W-1:0]           sram_rdata,
  output logic [vga_pkg::COLOR_W-1:0] rd_data,
  output logic [2:0]                  tag_out,
  output logic                        word_valid,
  output logic [ADDR_W-1:0]           sram_addr,
  output logic [DATA_W-1:0]           sram_wdata,
  output logic                        sram_we_n,
  output logic                        sram_oe_n,
  output logic                        sram_ce_n
);

  logic       valid_q;
  logic [2:0] tag_q;

  // stage 1 drives the pins
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sram_ce_n <= 1'b1;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      valid_q   <= 1'b0;
    end else begin
      sram_ce_n <= !(wr_en || rd_en);
      sram_we_n <= !wr_en;
      sram_oe_n <= !rd_en;
      // every raster position takes a slot, blanking included
      valid_q   <= pos_valid;
    end
  end

  always_ff @(posedge clk) begin
    sram_addr  <= wr_en ? wr_addr : rd_addr;
    sram_wdata <= wr_data;
    tag_q      <= tag;
  end

  // stage 2 samples the returned word, blanking positions carry black
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) word_valid <= 1'b0;
    else word_valid <= valid_q;
  end

  always_ff @(posedge clk) begin
    rd_data <= tag_q[0] ? sram_rdata[vga_pkg::COLOR_W-1:0] : '0;
    tag_out <= tag_q;
  end

  a_no_rw_overlap: assert property (@(posedge clk) disable iff (!arst_n)
    !(wr_en && rd_en));

  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    word_valid |-> $past(rd_en, 2) || !$past(tag[0], 2));

endmodule

//--- design/vga_pkg.sv
package vga_pkg;

  typedef enum logic [1:0] {
    IDLE,
    FILL,
    STREAM
  } seq_state_t;

  typedef enum logic [1:0] {
    PAT_SOLID,
    PAT_BARS,
    PAT_GRID,
    PAT_XOR
  } pattern_t;

  // packed pixel word: {hsync, vsync, active, red[3:0], green[3:0], blue[3:0]}
  localparam int PIX_W = 15;
  // colour lives in the low bits of the sram word
  localparam int COLOR_W = 12;

  function automatic logic [COLOR_W-1:0] pattern_color(input pattern_t pat,
                                                       input logic [15:0] x,
                                                       input logic [15:0] y);
    logic [COLOR_W-1:0] color;
    case (pat)
      PAT_SOLID: color = 12'hfff;
      PAT_BARS:  color = {x[3:0], 8'h00};
      // grid lines every fourth pixel in both directions
      PAT_GRID:  color = (x[1:0] == 2'b00 || y[1:0] == 2'b00) ? 12'hfff : 12'h000;
      PAT_XOR:   color = {x[3:0], y[3:0], x[3:0] ^ y[3:0]};
      default:   color = 12'h000;
    endcase
    return color;
  endfunction

endpackage

//--- design/vga_sram.sv
`timescale 1ns/1ps

module vga_sram #(
  parameter int ADDR_W          = 20,
  parameter int DATA_W          = 16,
  parameter int H_ACTIVE        = 8,
  parameter int H_TOTAL         = 12,
  parameter int H_SYNC_START    = 9,
  parameter int H_SYNC_END      = 10,
  parameter int V_ACTIVE        = 6,
  parameter int V_TOTAL         = 8,
  parameter int V_SYNC_START    = 6,
  parameter int V_SYNC_END      = 6,
  parameter int FIFO_DEPTH_LOG2 = 3,
  parameter int ALMOST_FULL_BUF = 4
) (
  input  logic              clk,
  input  logic              pixel_clk,
  input  logic              arst_n,
  input  logic              start,
  input  vga_pkg::pattern_t pattern,
  input  logic [DATA_W-1:0] sram_rdata,
  output logic              fill_done,
  output logic [ADDR_W-1:0] sram_addr,
  output logic [DATA_W-1:0] sram_wdata,
  output logic              sram_we_n,
  output logic              sram_oe_n,
  output logic              sram_ce_n,
  output logic [3:0]        vga_red,
  output logic [3:0]        vga_green,
  output logic [3:0]        vga_blue,
  output logic              vga_hsync,
  output logic              vga_vsync,
  output logic              vga_de
);

  logic                        fifo_almost_full;
  logic                        adv;
  logic                        wr_en;
  logic [ADDR_W-1:0]           wr_addr;
  logic [DATA_W-1:0]           wr_data;
  logic                        pos_valid;
  logic                        rd_en;
  logic [ADDR_W-1:0]           rd_addr;
  logic [2:0]                  tag;
  logic [vga_pkg::COLOR_W-1:0] rd_data;
  logic [2:0]                  tag_out;
  logic                        word_valid;
  logic [vga_pkg::PIX_W-1:0]   fifo_wdata;
  logic [vga_pkg::PIX_W-1:0]   fifo_rdata;
  logic                        fifo_rvalid;

  frame_seq #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
  ) u_frame_seq (
    .clk(clk), .arst_n(arst_n), .start(start), .pattern(pattern),
    .fifo_almost_full(fifo_almost_full), .fill_done(fill_done), .adv(adv),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  raster_timer #(
    .ADDR_W(ADDR_W), .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
    .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
    .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
    .V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END)
  ) u_raster_timer (
    .clk(clk), .arst_n(arst_n), .adv(adv), .pos_valid(pos_valid),
    .rd_en(rd_en), .rd_addr(rd_addr), .tag(tag)
  );

  sram_port #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W)
  ) u_sram_port (
    .clk(clk), .arst_n(arst_n), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .pos_valid(pos_valid), .rd_en(rd_en), .rd_addr(rd_addr), .tag(tag),
    .sram_rdata(sram_rdata), .rd_data(rd_data), .tag_out(tag_out),
    .word_valid(word_valid), .sram_addr(sram_addr), .sram_wdata(sram_wdata),
    .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n), .sram_ce_n(sram_ce_n)
  );

  // packed word is {hsync, vsync, active, red, green, blue}
  assign fifo_wdata = {tag_out, rd_data};

  pixel_fifo #(
    .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2), .ALMOST_FULL_BUF(ALMOST_FULL_BUF)
  ) u_pixel_fifo (
    .w_clk(clk), .w_arst_n(arst_n), .w_inc(word_valid), .w_data(fifo_wdata),
    .w_full(), .w_almost_full(fifo_almost_full),
    .r_clk(pixel_clk), .r_arst_n(arst_n), .r_valid(fifo_rvalid), .r_data(fifo_rdata)
  );

  // an empty fifo shows idle syncs and black
  assign vga_de    = fifo_rvalid;
  assign vga_hsync = fifo_rvalid ? fifo_rdata[14] : 1'b1;
  assign vga_vsync = fifo_rvalid ? fifo_rdata[13] : 1'b1;
  assign vga_red   = fifo_rvalid ? fifo_rdata[11:8] : 4'h0;
  assign vga_green = fifo_rvalid ? fifo_rdata[7:4] : 4'h0;
  assign vga_blue  = fifo_rvalid ? fifo_rdata[3:0] : 4'h0;

endmodule

//--- test/tb_vga_sram.sv
`timescale 1ns/1ps

module tb_vga_sram;

  localparam int H_ACTIVE     = 8;
  localparam int H_TOTAL      = 12;
  localparam int H_SYNC_START = 9;
  localparam int H_SYNC_END   = 10;
  localparam int V_ACTIVE     = 6;
  localparam int V_TOTAL      = 8;
  localparam int V_SYNC_START = 6;
  localparam int V_SYNC_END   = 6;
  localparam int RESET_CYCLES = 16;
  localparam int FILL_CYCLES  = H_ACTIVE * V_ACTIVE;
  localparam int FRAME_WORDS  = H_TOTAL * V_TOTAL;
  localparam int NUM_ROWS     = 4;

  logic              clk = 1'b0;
  logic              pixel_clk = 1'b0;
  logic              arst_n;
  logic              start;
  vga_pkg::pattern_t pattern;
  logic [15:0]       sram_rdata;
  logic              fill_done;
  logic [19:0]       sram_addr;
  logic [15:0]       sram_wdata;
  logic              sram_we_n;
  logic              sram_oe_n;
  logic              sram_ce_n;
  logic [3:0]        vga_red;
  logic [3:0]        vga_green;
  logic [3:0]        vga_blue;
  logic              vga_hsync;
  logic              vga_vsync;
  logic              vga_de;

  logic [15:0]       sram_mem [64];
  vga_pkg::pattern_t row_pat [NUM_ROWS];
  int                row_frames [NUM_ROWS];
  int                cycle_cnt = 0;
  int                row_start = 0;
  int                row_limit = 1000;

  always #20 clk = ~clk;
  always #28 pixel_clk = ~pixel_clk;

  vga_sram #(
    .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
    .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
    .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
    .V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END)
  ) UUT (
    .clk(clk), .pixel_clk(pixel_clk), .arst_n(arst_n), .start(start),
    .pattern(pattern), .sram_rdata(sram_rdata), .fill_done(fill_done),
    .sram_addr(sram_addr), .sram_wdata(sram_wdata), .sram_we_n(sram_we_n),
    .sram_oe_n(sram_oe_n), .sram_ce_n(sram_ce_n), .vga_red(vga_red),
    .vga_green(vga_green), .vga_blue(vga_blue), .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync), .vga_de(vga_de)
  );

  // asynchronous sram, only the low address bits are decoded
  always @(posedge clk) begin
    if (!sram_ce_n && !sram_we_n) sram_mem[sram_addr[5:0]] <= sram_wdata;
  end

  assign sram_rdata = sram_oe_n ? 16'h0000 : sram_mem[sram_addr[5:0]];

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt - row_start > row_limit) begin
      $display("timeout: no progress after %0d clk cycles in this row", row_limit);
      $display("Testbench failed");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  // colour rules of the four test patterns
  function automatic logic [11:0] expected_color(input vga_pkg::pattern_t pat,
                                                 input int px, input int py);
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    r = 4'h0;
    g = 4'h0;
    b = 4'h0;
    if (pat == vga_pkg::PAT_SOLID || (pat == vga_pkg::PAT_GRID &&
        (px % 4 == 0 || py % 4 == 0))) begin
      r = 4'hf;
      g = 4'hf;
      b = 4'hf;
    end else if (pat == vga_pkg::PAT_BARS) begin
      r = 4'(px);
    end else if (pat == vga_pkg::PAT_XOR) begin
      r = 4'(px);
      g = 4'(py);
      b = 4'(px) ^ 4'(py);
    end
    return {r, g, b};
  endfunction

  task automatic stop_on_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
    $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_color(input string name, input logic [11:0] got,
                             input logic [11:0] exp);
    if (got !== exp) stop_on_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_sync(input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) stop_on_mismatch("vga_hsync,vga_vsync", 32'(got), 32'(exp));
  endtask

  task automatic check_state(input logic got, input logic exp);
    if (got !== exp) stop_on_mismatch("fill_done", 32'(got), 32'(exp));
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) stop_on_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) stop_on_mismatch(name, got, exp);
  endtask

  initial begin
    int fill_cycles;
    int words;
    int rx;
    int ry;
    logic [11:0] exp_col;
    logic [1:0]  exp_sync;

    arst_n  <= 1'b0;
    start   <= 1'b0;
    pattern <= vga_pkg::PAT_SOLID;
    row_pat[0] = vga_pkg::PAT_SOLID;
    row_pat[1] = vga_pkg::PAT_BARS;
    row_pat[2] = vga_pkg::PAT_GRID;
    row_pat[3] = vga_pkg::PAT_XOR;
    for (int i = 0; i < NUM_ROWS; i++) row_frames[i] = 2;

    for (int i = 0; i < NUM_ROWS; i++) begin
      row_start = cycle_cnt;
      row_limit = (RESET_CYCLES + FILL_CYCLES + row_frames[i] * FRAME_WORDS) * 3 + 64;
      @(posedge clk);
      arst_n  <= 1'b0;
      pattern <= row_pat[i];
      // contents before each fill differ from every pattern word
      for (int a = 0; a < 64; a++) sram_mem[a] <= 16'hb700 ^ 16'(a * 3);
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      repeat (2) @(negedge clk);
      check_state(fill_done, 1'b0);
      check_level("vga_de", vga_de, 1'b0);
      check_level("sram_ce_n", sram_ce_n, 1'b1);
      check_level("sram_we_n", sram_we_n, 1'b1);
      check_level("sram_oe_n", sram_oe_n, 1'b1);

      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      fill_cycles = 0;
      @(negedge clk);
      while (!fill_done) begin
        fill_cycles++;
        @(negedge clk);
      end
      check_count("fill cycles", fill_cycles, FILL_CYCLES);

      // last write lands one edge after the pins
      repeat (2) @(negedge clk);
      for (int a = 0; a < FILL_CYCLES; a++) begin
        check_color("sram_mem", sram_mem[a][11:0],
                    expected_color(row_pat[i], a % H_ACTIVE, a / H_ACTIVE));
      end

      words = 0;
      rx = 0;
      ry = 0;
      while (words < row_frames[i] * FRAME_WORDS) begin
        @(negedge pixel_clk);
        if (vga_de) begin
          exp_col = (rx < H_ACTIVE && ry < V_ACTIVE) ?
                    expected_color(row_pat[i], rx, ry) : 12'h000;
          exp_sync[1] = !(rx >= H_SYNC_START && rx <= H_SYNC_END);
          exp_sync[0] = !(ry >= V_SYNC_START && ry <= V_SYNC_END);
          check_color("vga_red,vga_green,vga_blue", {vga_red, vga_green, vga_blue},
                      exp_col);
          check_sync({vga_hsync, vga_vsync}, exp_sync);
          words++;
          if (rx == H_TOTAL - 1) begin
            rx = 0;
            ry = (ry == V_TOTAL - 1) ? 0 : ry + 1;
          end else begin
            rx++;
          end
        end
      end
      $display("pattern %0d: %0d words checked", i, words);
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- verilog.f
design/vga_pkg.sv
design/frame_seq.sv
design/raster_timer.sv
design/sram_port.sv
design/pixel_fifo.sv
design/vga_sram.sv
test/tb_vga_sram.sv
